// ==== files.f ====
source/asi_w_pkg.sv
source/sync_fifo.sv
source/burst_addr_gen.sv
source/wburst_ctrl.sv
source/asi_w_top.sv
verif/asi_w_checker.sv
verif/tb_asi_w.sv

// ==== verif/tb_asi_w.sv ====
// Testbench for the AXI4 write slave port
// Bursts from a table, random grant and BREADY, comparison in asi_w_checker

module tb_asi_w;

    localparam int name_w      = 8 * 16;
    localparam int step_limit  = 200;
    localparam int drain_limit = 4000;

    // One table row per burst, expected BRESP included
    typedef struct packed {
        logic [name_w-1:0]             name;
        logic [asi_w_pkg::id_w-1:0]    id;
        logic [asi_w_pkg::addr_w-1:0]  addr;
        logic [asi_w_pkg::len_w-1:0]   len;
        logic [asi_w_pkg::size_w-1:0]  size;
        logic [1:0]                    burst;
        logic [1:0]                    resp;
        logic                          hold_b;
    } stim_t;

    logic                   clk;
    logic                   rst_n;
    logic                   awvalid;
    logic                   awready;
    logic                   wvalid;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic                   usr_wrequest;
    logic                   usr_wgrant;
    logic                   usr_we;
    logic                   drained;
    asi_w_pkg::aw_beat_t    aw;
    asi_w_pkg::w_beat_t     w;
    asi_w_pkg::b_resp_t     b;
    asi_w_pkg::usr_write_t  usr_write;
    logic [name_w-1:0]      cur_name;
    logic [1:0]             cur_resp;
    logic [31:0]            data_cnt;
    logic [31:0]            rnd;
    logic                   b_hold;
    logic                   aborted;
    int                     seed;
    int                     timeouts;
    int                     mismatches;
    int                     other_errors;
    stim_t                  stim [$];

    asi_w_top #(.aw_depth(4), .w_depth(16), .b_depth(4)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .usr_wrequest(usr_wrequest), .usr_wgrant(usr_wgrant),
        .usr_we(usr_we), .usr_write(usr_write)
    );

    asi_w_checker #(.name_w(name_w)) chk0 (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .usr_wrequest(usr_wrequest),
        .usr_we(usr_we), .usr_write(usr_write),
        .cur_name(cur_name), .cur_resp(cur_resp),
        .mismatches(mismatches), .other_errors(other_errors), .drained(drained)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Arbiter grant and BREADY, one draw per falling edge
    always @(negedge clk) begin
        rnd        = $random(seed);
        usr_wgrant = (rnd[1:0] != 2'b00);
        bready     = !b_hold && rnd[4];
    end

    // --------------------------------------------------
    // Stimulus table
    task automatic add_test(input logic [name_w-1:0] name, input logic [3:0] id,
                            input logic [31:0] addr, input logic [7:0] len,
                            input logic [2:0] size, input logic [1:0] burst,
                            input logic [1:0] resp, input logic hold_b);
        stim.push_back('{name: name, id: id, addr: addr, len: len, size: size,
                         burst: burst, resp: resp, hold_b: hold_b});
    endtask

    task automatic build_table();
        add_test("single_incr", 4'h1, 32'h0000_1003, 8'd0, 3'd2, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b0);
        add_test("incr8_unalign", 4'h2, 32'h0000_2106, 8'd7, 3'd2, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b0);
        add_test("fixed4", 4'h3, 32'h0000_3040, 8'd3, 3'd2, asi_w_pkg::burst_fixed,
                 asi_w_pkg::resp_okay, 1'b0);
        add_test("page_hold", 4'h4, 32'h0000_4ff8, 8'd5, 3'd2, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b0);
        add_test("size3_slverr", 4'h5, 32'h0000_5104, 8'd2, 3'd3, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_slverr, 1'b0);
        add_test("incr_half", 4'h6, 32'h0000_6001, 8'd3, 3'd1, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b0);
        // B channel blocked, enough bursts to fill the response buffer and stall
        add_test("bhold_a", 4'h7, 32'h0000_7000, 8'd1, 3'd2, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b1);
        add_test("bhold_b", 4'h8, 32'h0000_7100, 8'd0, 3'd2, asi_w_pkg::burst_fixed,
                 asi_w_pkg::resp_okay, 1'b1);
        // RESERVED burst code, addressed like INCR
        add_test("bhold_c", 4'h9, 32'h0000_7202, 8'd3, 3'd2, 2'b11,
                 asi_w_pkg::resp_okay, 1'b1);
        add_test("bhold_d", 4'ha, 32'h0000_7ffc, 8'd2, 3'd2, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b1);
        add_test("bhold_e", 4'hb, 32'h0000_7300, 8'd1, 3'd3, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_slverr, 1'b1);
        add_test("bhold_f", 4'hc, 32'h0000_7400, 8'd2, 3'd0, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b1);
        add_test("bhold_g", 4'hd, 32'h0000_7500, 8'd0, 3'd2, asi_w_pkg::burst_incr,
                 asi_w_pkg::resp_okay, 1'b1);
    endtask

    // --------------------------------------------------
    // Ready depends on registered flags only, so it is settled at the falling edge
    task automatic wait_ready(input bit for_aw);
        int cycles;
        cycles = 0;
        while (!(for_aw ? awready : wready) && cycles < step_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!(for_aw ? awready : wready)) begin
            $display("Timeout: %0s stayed low for %0d cycles", for_aw ? "awready" : "wready",
                     step_limit);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    // AW first, then len+1 data beats with a running counter
    task automatic send_burst(input stim_t s);
        int k;
        // BREADY process picks the new hold on the next falling edge
        b_hold   <= s.hold_b;
        cur_name = s.name;
        cur_resp = s.resp;
        aw       = '{id: s.id, addr: s.addr, len: s.len, size: s.size, burst: s.burst};
        awvalid  = 1'b1;
        wait_ready(1'b1);
        @(negedge clk);
        awvalid = 1'b0;
        for (k = 0; k <= s.len && !aborted; k++) begin
            w      = '{data: data_cnt, strb: '1, last: (k == s.len)};
            wvalid = 1'b1;
            wait_ready(1'b0);
            @(negedge clk);
            data_cnt = data_cnt + 1;
        end
        wvalid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (drained !== 1'b1 && cycles < drain_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (drained !== 1'b1) begin
            $display("Timeout: beats or responses still outstanding after %0d cycles",
                     drain_limit);
            timeouts++;
        end
    endtask

    task automatic report();
        $display("Errors: %0d mismatches, %0d other, %0d timeouts", mismatches, other_errors,
                 timeouts);
        if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // Main sequence
    initial begin
        int i;
        seed       = 32'hf8e69d85;
        rst_n      = 1'b0;
        awvalid    = 1'b0;
        aw         = '0;
        wvalid     = 1'b0;
        w          = '0;
        bready     = 1'b0;
        usr_wgrant = 1'b0;
        b_hold     = 1'b0;
        cur_name   = '0;
        cur_resp   = 2'b00;
        data_cnt   = 32'h1000_0000;
        aborted    = 1'b0;
        timeouts   = 0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (i = 0; i < stim.size() && !aborted; i++) begin
            send_burst(stim[i]);
        end
        // Let held responses drain
        b_hold <= 1'b0;
        wait_drain();
        report();
    end

endmodule

// ==== verif/asi_w_checker.sv ====
// Scoreboard for the AXI4 write slave port
// Predicts user beats and B responses from the AW and W transfers seen at the ports

module asi_w_checker #(
    parameter int name_w = 128
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   awvalid,
    input  logic                   awready,
    input  asi_w_pkg::aw_beat_t    aw,
    input  logic                   wvalid,
    input  logic                   wready,
    input  asi_w_pkg::w_beat_t     w,
    input  logic                   bvalid,
    input  logic                   bready,
    input  asi_w_pkg::b_resp_t     b,
    input  logic                   usr_wrequest,
    input  logic                   usr_we,
    input  asi_w_pkg::usr_write_t  usr_write,
    // Test name and expected BRESP of the burst on the AW port
    input  logic [name_w-1:0]      cur_name,
    input  logic [1:0]             cur_resp,
    output int                     mismatches,
    output int                     other_errors,
    output logic                   drained
);

    asi_w_pkg::aw_beat_t  aw_q [$];
    asi_w_pkg::w_beat_t   w_q [$];
    logic [name_w-1:0]    name_q [$];
    logic [1:0]           resp_q [$];
    asi_w_pkg::b_resp_t   bexp_q [$];
    logic [name_w-1:0]    bname_q [$];
    asi_w_pkg::aw_beat_t  cur;
    logic [name_w-1:0]    cur_test;
    logic [1:0]           burst_resp;
    logic                 in_burst;
    int                   beat_idx;
    int                   n_mismatch;
    int                   n_other;

    assign mismatches   = n_mismatch;
    assign other_errors = n_other;

    initial begin
        n_mismatch = 0;
        n_other    = 0;
        in_burst   = 1'b0;
        beat_idx   = 0;
        drained    = 1'b0;
    end

    // --------------------------------------------------
    // Reference address of beat k
    // Beat 0 at the raw start, then aligned steps that stop at the page edge
    function automatic logic [31:0] model_addr(asi_w_pkg::aw_beat_t bt, int k);
        logic [31:0] a;
        logic [31:0] step;
        logic [31:0] nxt;
        int          cap;
        int          i;
        cap  = (bt.size > asi_w_pkg::max_size) ? asi_w_pkg::max_size : int'(bt.size);
        a    = (bt.addr >> cap) << cap;
        step = (bt.burst == asi_w_pkg::burst_fixed) ? 32'd0 : (32'd1 << bt.size);
        for (i = 1; i <= k; i++) begin
            nxt = a + step;
            if (nxt[31:12] == bt.addr[31:12]) begin
                a = nxt;
            end
        end
        return (k == 0) ? bt.addr : a;
    endfunction

    task automatic compare(input logic [name_w-1:0] test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %0s %0s: expected %h actual %h", test, field, exp, act);
            n_mismatch++;
        end
    endtask

    // --------------------------------------------------
    // Arbiter request, only while a burst has address and data waiting
    task automatic check_request();
        if (usr_we && !usr_wrequest) begin
            $display("User beat issued while no request was raised");
            n_other++;
        end
        if (usr_wrequest && (w_q.size() == 0 || (!in_burst && aw_q.size() == 0))) begin
            $display("Request raised with no burst or no write data waiting");
            n_other++;
        end
    endtask

    // User port, one beat per usr_we
    task automatic check_user_beat();
        asi_w_pkg::w_beat_t wb;
        if (!usr_we) begin
            // Strobes must stay quiet between beats
            compare("idle", "strb", 32'(0), 32'(usr_write.strb));
            compare("idle", "last", 32'(0), 32'(usr_write.last));
        end else if (!in_burst && aw_q.size() == 0) begin
            $display("User beat at address %h arrived with no accepted burst", usr_write.addr);
            n_other++;
        end else if (w_q.size() == 0) begin
            $display("User beat at address %h arrived with no accepted write data",
                     usr_write.addr);
            n_other++;
        end else begin
            if (!in_burst) begin
                cur        = aw_q.pop_front();
                cur_test   = name_q.pop_front();
                burst_resp = resp_q.pop_front();
                beat_idx   = 0;
                in_burst   = 1'b1;
            end
            wb = w_q.pop_front();
            compare(cur_test, $sformatf("beat %0d id", beat_idx), 32'(cur.id), 32'(usr_write.id));
            compare(cur_test, $sformatf("beat %0d addr", beat_idx), model_addr(cur, beat_idx),
                    usr_write.addr);
            compare(cur_test, $sformatf("beat %0d data", beat_idx), wb.data, usr_write.data);
            compare(cur_test, $sformatf("beat %0d strb", beat_idx), 32'(wb.strb),
                    32'(usr_write.strb));
            compare(cur_test, $sformatf("beat %0d last", beat_idx), 32'(beat_idx == cur.len),
                    32'(usr_write.last));
            if (beat_idx == cur.len) begin
                // Burst done, its response is now owed
                bexp_q.push_back('{id: cur.id, resp: burst_resp});
                bname_q.push_back(cur_test);
                in_burst = 1'b0;
            end else begin
                beat_idx++;
            end
        end
    endtask

    // Responses come back in AW order
    task automatic check_response();
        asi_w_pkg::b_resp_t exp_b;
        logic [name_w-1:0]  test;
        if (bvalid && bready) begin
            if (bexp_q.size() == 0) begin
                $display("Response with id %h arrived with no finished burst", b.id);
                n_other++;
            end else begin
                exp_b = bexp_q.pop_front();
                test  = bname_q.pop_front();
                compare(test, "bresp id", 32'(exp_b.id), 32'(b.id));
                compare(test, "bresp code", 32'(exp_b.resp), 32'(b.resp));
            end
        end
    endtask

    // --------------------------------------------------
    // Sample at the rising edge, before the DUT registers move
    always @(posedge clk) begin
        if (rst_n) begin
            check_request();
            check_user_beat();
            check_response();
            if (awvalid && awready) begin
                aw_q.push_back(aw);
                name_q.push_back(cur_name);
                resp_q.push_back(cur_resp);
            end
            if (wvalid && wready) begin
                w_q.push_back(w);
            end
        end
        drained = (aw_q.size() == 0) && (w_q.size() == 0) && !in_burst &&
                  (bexp_q.size() == 0);
    end

endmodule

// ==== source/asi_w_top.sv ====
// AXI4 write slave port, single clock
// AW, W and B buffers around the burst controller and the beat address generator

module asi_w_top #(
    parameter int aw_depth = 4,
    parameter int w_depth  = 16,
    parameter int b_depth  = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // AXI write address
    input  logic                   awvalid,
    output logic                   awready,
    input  asi_w_pkg::aw_beat_t    aw,
    // AXI write data
    input  logic                   wvalid,
    output logic                   wready,
    input  asi_w_pkg::w_beat_t     w,
    // AXI write response
    output logic                   bvalid,
    input  logic                   bready,
    output asi_w_pkg::b_resp_t     b,
    // User logic and arbiter
    output logic                   usr_wrequest,
    input  logic                   usr_wgrant,
    output logic                   usr_we,
    output asi_w_pkg::usr_write_t  usr_write
);

    localparam int aw_width = $bits(asi_w_pkg::aw_beat_t);
    localparam int w_width  = $bits(asi_w_pkg::w_beat_t);
    localparam int b_width  = $bits(asi_w_pkg::b_resp_t);

    asi_w_pkg::aw_beat_t            aw_head;
    asi_w_pkg::w_beat_t             w_head;
    asi_w_pkg::b_resp_t             b_entry;
    logic                           aw_full;
    logic                           aw_empty;
    logic                           aw_pop;
    logic                           w_full;
    logic                           w_empty;
    logic                           w_pop;
    logic                           b_full;
    logic                           b_empty;
    logic                           b_push;
    logic                           addr_load;
    logic                           addr_advance;
    logic [asi_w_pkg::addr_w-1:0]   beat_addr;
    logic                           last_beat;

    // --------------------------------------------------
    // AXI handshakes, ready follows buffer room
    assign awready = !aw_full;
    assign wready  = !w_full;
    assign bvalid  = !b_empty;

    sync_fifo #(.depth(aw_depth), .width(aw_width)) aw_buffer (
        .clk(clk), .rst_n(rst_n),
        .we(awvalid && awready), .re(aw_pop), .d(aw),
        .q(aw_head), .full(aw_full), .empty(aw_empty)
    );

    sync_fifo #(.depth(w_depth), .width(w_width)) w_buffer (
        .clk(clk), .rst_n(rst_n),
        .we(wvalid && wready), .re(w_pop), .d(w),
        .q(w_head), .full(w_full), .empty(w_empty)
    );

    // Response head drives the B channel directly
    sync_fifo #(.depth(b_depth), .width(b_width)) b_buffer (
        .clk(clk), .rst_n(rst_n),
        .we(b_push), .re(bvalid && bready), .d(b_entry),
        .q(b), .full(b_full), .empty(b_empty)
    );

    // --------------------------------------------------
    // Burst control
    wburst_ctrl ctrl0 (
        .clk(clk), .rst_n(rst_n),
        .aw_head(aw_head), .aw_empty(aw_empty),
        .w_head(w_head), .w_empty(w_empty), .b_full(b_full),
        .aw_pop(aw_pop), .w_pop(w_pop), .b_push(b_push), .b_entry(b_entry),
        .addr_load(addr_load), .addr_advance(addr_advance),
        .beat_addr(beat_addr), .last_beat(last_beat),
        .usr_wrequest(usr_wrequest), .usr_wgrant(usr_wgrant),
        .usr_we(usr_we), .usr_write(usr_write)
    );

    // Address generator sees the AW head while loading
    burst_addr_gen addr0 (
        .clk(clk), .rst_n(rst_n),
        .load(addr_load), .advance(addr_advance), .aw(aw_head),
        .beat_addr(beat_addr), .last_beat(last_beat)
    );

endmodule

// ==== source/wburst_ctrl.sv ====
// Write burst controller
// Pops AW and W under grant, issues user beats and pushes one response per burst

module wburst_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  asi_w_pkg::aw_beat_t           aw_head,
    input  logic                          aw_empty,
    input  asi_w_pkg::w_beat_t            w_head,
    input  logic                          w_empty,
    input  logic                          b_full,
    output logic                          aw_pop,
    output logic                          w_pop,
    output logic                          b_push,
    output asi_w_pkg::b_resp_t            b_entry,
    output logic                          addr_load,
    output logic                          addr_advance,
    input  logic [asi_w_pkg::addr_w-1:0]  beat_addr,
    input  logic                          last_beat,
    output logic                          usr_wrequest,
    input  logic                          usr_wgrant,
    output logic                          usr_we,
    output asi_w_pkg::usr_write_t         usr_write
);

    asi_w_pkg::burst_phase_t phase;
    asi_w_pkg::burst_phase_t phase_nxt;
    asi_w_pkg::aw_beat_t     aw_q;
    asi_w_pkg::aw_beat_t     cur_aw;
    logic                    beat;
    logic                    end_beat;
    logic [1:0]              resp;

    // --------------------------------------------------
    // Request and beat strobes
    // First beat needs both an address and data
    assign usr_wrequest = (phase == asi_w_pkg::phase_first && !aw_empty && !w_empty) ||
                          (phase == asi_w_pkg::phase_burst && !w_empty);
    assign beat         = usr_wrequest && usr_wgrant;
    assign end_beat     = beat && last_beat;

    assign aw_pop       = beat && (phase == asi_w_pkg::phase_first);
    assign w_pop        = beat;
    assign addr_load    = aw_pop;
    assign addr_advance = beat && (phase == asi_w_pkg::phase_burst);
    assign usr_we       = beat;

    // Head of AW buffer in the first beat, latched copy later
    assign cur_aw = (phase == asi_w_pkg::phase_first) ? aw_head : aw_q;

    // Oversized transfers are still carried out, but flagged
    assign resp = (cur_aw.size > asi_w_pkg::size_w'(asi_w_pkg::max_size)) ?
                  asi_w_pkg::resp_slverr : asi_w_pkg::resp_okay;

    // Response goes out on the last beat or from the wait phase
    assign b_push  = !b_full && (end_beat || phase == asi_w_pkg::phase_bresp);
    assign b_entry = '{id: cur_aw.id, resp: resp};

    // --------------------------------------------------
    // User beat, strobes zeroed between beats
    assign usr_write.id   = cur_aw.id;
    assign usr_write.addr = beat_addr;
    assign usr_write.data = w_head.data;
    assign usr_write.strb = usr_we ? w_head.strb : '0;
    assign usr_write.last = usr_we ? last_beat : 1'b0;

    // --------------------------------------------------
    // Phase FSM
    always_comb begin
        phase_nxt = phase;
        case (phase)
            asi_w_pkg::phase_idle: phase_nxt = asi_w_pkg::phase_first;
            asi_w_pkg::phase_first: begin
                // Single-beat burst finishes in the same cycle
                if (aw_pop) begin
                    if (!last_beat) begin
                        phase_nxt = asi_w_pkg::phase_burst;
                    end else if (b_full) begin
                        phase_nxt = asi_w_pkg::phase_bresp;
                    end
                end
            end
            asi_w_pkg::phase_burst: begin
                if (end_beat) begin
                    phase_nxt = b_full ? asi_w_pkg::phase_bresp : asi_w_pkg::phase_first;
                end
            end
            asi_w_pkg::phase_bresp: begin
                if (!b_full) begin
                    phase_nxt = asi_w_pkg::phase_first;
                end
            end
            default: phase_nxt = asi_w_pkg::phase_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= asi_w_pkg::phase_idle;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Burst copy for id and size after beat 0
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            aw_q <= aw_head;
        end
    end

    // WLAST from the master lines up with the beat count of the burst
    a_wlast_match: assert property (@(posedge clk) disable iff (!rst_n)
        usr_we |-> w_head.last == last_beat);

endmodule

// ==== source/burst_addr_gen.sv ====
// Burst beat address generator
// FIXED and INCR addressing, size alignment after beat 0, hold at the 4 KB page edge

module burst_addr_gen (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  logic                          advance,
    input  asi_w_pkg::aw_beat_t           aw,
    output logic [asi_w_pkg::addr_w-1:0]  beat_addr,
    output logic                          last_beat
);

    localparam int addr_w = asi_w_pkg::addr_w;

    asi_w_pkg::aw_beat_t                 aw_q;
    asi_w_pkg::aw_beat_t                 cur;
    logic [asi_w_pkg::len_w-1:0]         beat_cnt;
    logic [addr_w-1:0]                   addr_q;
    logic [asi_w_pkg::size_w-1:0]        size_cap;
    logic [addr_w-1:0]                   incr;
    logic [addr_w-1:0]                   aligned;
    logic [addr_w-1:0]                   base;
    logic [addr_w-1:0]                   next;
    logic [addr_w-1:0]                   next_held;

    // --------------------------------------------------
    // Next beat address
    // Burst under work is the input during load and the latched copy after
    assign cur      = load ? aw : aw_q;
    // Alignment never goes past the bus width
    assign size_cap = (cur.size > asi_w_pkg::size_w'(asi_w_pkg::max_size)) ?
                      asi_w_pkg::size_w'(asi_w_pkg::max_size) : cur.size;
    assign incr     = (cur.burst == asi_w_pkg::burst_fixed) ? '0 : addr_w'(1) << cur.size;
    assign aligned  = cur.addr & ({addr_w{1'b1}} << size_cap);
    assign base     = load ? aligned : addr_q;
    assign next     = base + incr;
    // Stay on the last address of the page instead of crossing it
    assign next_held = (next[12] != cur.addr[12]) ? base : next;

    // Beat 0 goes out at the unaligned start address
    assign beat_addr = load ? aw.addr : addr_q;
    assign last_beat = load ? (aw.len == '0) : (beat_cnt == aw_q.len);

    // --------------------------------------------------
    // Counter and address register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            addr_q   <= '0;
        end else if (load) begin
            beat_cnt <= asi_w_pkg::len_w'(1);
            addr_q   <= next_held;
        end else if (advance) begin
            beat_cnt <= beat_cnt + 1'b1;
            addr_q   <= next_held;
        end
    end

    // Burst copy for beats after the first
    always_ff @(posedge clk) begin
        if (load) begin
            aw_q <= aw;
        end
    end

    // Every later beat stays within the page of the start address
    a_page_hold: assert property (@(posedge clk) disable iff (!rst_n)
        advance |-> beat_addr[addr_w-1:12] == aw_q.addr[addr_w-1:12]);

endmodule

// ==== source/sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO
// Head entry shows on q while not empty, full and empty are registered

module sync_fifo #(
    parameter int depth = 4,
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  logic             re,
    input  logic [width-1:0] d,
    output logic [width-1:0] q,
    output logic             full,
    output logic             empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_nxt;

    // Occupancy after this edge
    always_comb begin
        count_nxt = count;
        if (we && !re) begin
            count_nxt = count + 1'b1;
        end else if (re && !we) begin
            count_nxt = count - 1'b1;
        end
    end

    // --------------------------------------------------
    // Pointers, count and flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            // Wrap explicitly, depth need not be a power of two
            if (we) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (re) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_nxt;
            full  <= (count_nxt == cnt_w'(depth));
            empty <= (count_nxt == '0);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_ptr] <= d;
        end
    end

    // Fall-through read of the head entry
    assign q = mem[rd_ptr];

    // Callers gate their strobes with the flags
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) we |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) re |-> !empty);

endmodule

// ==== source/asi_w_pkg.sv ====
// AXI4 write slave port shared definitions
// Bus widths, burst and response codes, channel structs and the burst phase type

package asi_w_pkg;

    // --------------------------------------------------
    // Bus widths
    localparam int data_w   = 32;
    localparam int addr_w   = 32;
    localparam int id_w     = 4;
    localparam int len_w    = 8;
    localparam int size_w   = 3;
    // Bytes per beat and the largest legal AWSIZE
    localparam int bytes    = data_w / 8;
    localparam int max_size = $clog2(bytes);

    // --------------------------------------------------
    // AWBURST codes, RESERVED (2'b11) falls through to INCR
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;
    // BRESP codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // --------------------------------------------------
    // AW buffer entry, 49 bits
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [size_w-1:0] size;
        logic [1:0]        burst;
    } aw_beat_t;

    // W buffer entry, 37 bits
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [bytes-1:0]  strb;
        logic              last;
    } w_beat_t;

    // B buffer entry and response outputs
    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_resp_t;

    // One beat toward user logic
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [bytes-1:0]  strb;
        logic              last;
    } usr_write_t;

    // Burst controller phases
    typedef enum logic [1:0] {
        phase_first = 2'b00,
        phase_burst,
        phase_bresp,
        phase_idle
    } burst_phase_t;

endpackage
